//--- hw/apb_mem_bridge.sv
module apb_mem_bridge #(
  parameter int DATA_WIDTH = mem_pkg::MEM_DATA_W,
  parameter int ADDR_WIDTH = mem_pkg::MEM_ADDR_W
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  mem_pkg::apb_req_t     apb_i,
  input  logic [DATA_WIDTH-1:0] mem_rdata_i,
  output mem_pkg::apb_rsp_t     apb_o,
  output mem_pkg::mem_req_t     mem_o
);

  import mem_pkg::*;

  localparam int HI_W     = DATA_WIDTH - APB_DATA_W;  // Bits behind the high window
  localparam int HI_TILES = MEM_TILES - APB_STRB_W;   // Tiles behind the high window

  logic                access;
  logic                aligned;
  logic                hi_sel;
  logic                wr_lo;
  logic                wr_hi;
  logic                rd_lo;
  logic                rd_hi;
  logic                rd_pend_q;     // Low read issued, data due this cycle
  logic [HI_W-1:0]     stage_data_q;
  logic [HI_TILES-1:0] stage_strb_q;
  logic [HI_W-1:0]     rd_latch_q;    // Upper bits of the last low read

  // Address and window decode
  assign access  = apb_i.psel & apb_i.penable;
  assign aligned = (apb_i.paddr[1:0] == 2'b00);
  assign hi_sel  = apb_i.paddr[2];

  assign wr_lo = access & aligned & apb_i.pwrite & ~hi_sel;
  assign wr_hi = access & aligned & apb_i.pwrite & hi_sel;
  assign rd_lo = access & aligned & ~apb_i.pwrite & ~hi_sel;
  assign rd_hi = access & aligned & ~apb_i.pwrite & hi_sel;

  // Low read waits one cycle for the SRAM
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rd_pend_q <= 1'b0;
    end else begin
      rd_pend_q <= rd_lo & ~rd_pend_q;
    end
  end

  // Staged strobes and the read latch
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      stage_strb_q <= '0;
      rd_latch_q   <= '0;
    end else begin
      if (wr_hi) begin
        stage_strb_q <= apb_i.pstrb[HI_TILES-1:0];
      end else if (wr_lo) begin
        stage_strb_q <= '0;  // Consumed by the commit
      end
      if (rd_lo && rd_pend_q) begin
        rd_latch_q <= mem_rdata_i[DATA_WIDTH-1:APB_DATA_W];
      end
    end
  end

  // Staged high data, only meaningful where a strobe is set
  always_ff @(posedge clk_i) begin
    if (wr_hi) begin
      stage_data_q <= apb_i.pwdata[HI_W-1:0];
    end
  end

  // Memory request
  always_comb begin
    mem_o.v    = wr_lo | (rd_lo & ~rd_pend_q);
    mem_o.w    = apb_i.pwrite;
    mem_o.addr = apb_i.paddr[ADDR_WIDTH+2:3];
    mem_o.data = {stage_data_q, apb_i.pwdata};  // Commit staged high with low
    mem_o.mask = {stage_strb_q, apb_i.pstrb};
  end

  // APB response
  always_comb begin
    apb_o.pready  = access & ~(rd_lo & ~rd_pend_q);
    apb_o.pslverr = access & ~aligned;
    if (rd_lo && rd_pend_q) begin
      apb_o.prdata = mem_rdata_i[APB_DATA_W-1:0];
    end else if (rd_hi) begin
      apb_o.prdata = APB_DATA_W'(rd_latch_q);  // Zero-extended
    end else begin
      apb_o.prdata = '0;
    end
  end

  a_penable_with_psel: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    !(apb_i.penable && !apb_i.psel)
  ) else $error("apb_mem_bridge: penable high without psel");

  // Master must hold the transfer through the wait state
  a_req_stable: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (access && !apb_o.pready) |=> $stable(apb_i)
  ) else $error("apb_mem_bridge: request changed while pready low");

endmodule

//--- hw/mem_1rw_wrapper.sv
module mem_1rw_wrapper #(
  parameter int DATA_WIDTH = mem_pkg::MEM_DATA_W,
  parameter int ADDR_WIDTH = mem_pkg::MEM_ADDR_W
) (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic                         v_i,
  input  logic                         w_i,
  input  logic [ADDR_WIDTH-1:0]        addr_i,
  input  logic [DATA_WIDTH-1:0]        data_i,
  input  logic [mem_pkg::MEM_TILES-1:0] write_mask_i,
  output logic [DATA_WIDTH-1:0]        data_o
);

  import mem_pkg::*;

  // One byte tile per slice of the word
  for (genvar t = 0; t < MEM_TILES; t++) begin : g_tile
    localparam int LO   = 8 * t;
    localparam int BITS = (DATA_WIDTH - LO > 8) ? 8 : DATA_WIDTH - LO;

    logic [7:0] wd;
    logic [7:0] rd;

    always_comb begin
      wd = '0;                           // Unused bits of a partial tile
      wd[BITS-1:0] = data_i[LO +: BITS];
    end

    sram_256x8 u_sram (
      .clk_i    (clk_i),
      .ce_i     (v_i),
      .we_i     (w_i),
      .w_mask_i ({8{write_mask_i[t]}}),
      .addr_i   (addr_i),
      .wd_i     (wd),
      .rd_o     (rd)
    );

    assign data_o[LO +: BITS] = rd[BITS-1:0];  // Spare bits dropped
  end

  // Word must fit the tile row, and tiles are 256 deep
  a_tile_geometry: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (DATA_WIDTH <= 8 * MEM_TILES) && (DATA_WIDTH > 8 * (MEM_TILES - 1)) && (ADDR_WIDTH == 8)
  ) else $error("mem_1rw_wrapper: word width does not match the tile count");

  // A write with no tile selected is a bridge bug
  a_mask_nonzero: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (v_i && w_i) |-> (|write_mask_i)
  ) else $error("mem_1rw_wrapper: write issued with an all-zero mask");

endmodule

//--- hw/mem_pkg.sv
package mem_pkg;

  // Memory geometry
  localparam int MEM_DATA_W = 46;
  localparam int MEM_ADDR_W = 8;
  localparam int MEM_TILES  = (MEM_DATA_W + 7) / 8;  // Byte tiles, last one partial

  // APB side, word index + window bit + byte offset
  localparam int APB_ADDR_W = MEM_ADDR_W + 3;
  localparam int APB_DATA_W = 32;
  localparam int APB_STRB_W = APB_DATA_W / 8;

  // Master to slave
  typedef struct packed {
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [APB_ADDR_W-1:0] paddr;
    logic [APB_DATA_W-1:0] pwdata;
    logic [APB_STRB_W-1:0] pstrb;
  } apb_req_t;

  // Slave to master
  typedef struct packed {
    logic [APB_DATA_W-1:0] prdata;
    logic                  pready;
    logic                  pslverr;
  } apb_rsp_t;

  // Bridge to tiled memory
  typedef struct packed {
    logic                  v;     // Access valid
    logic                  w;     // Write when high
    logic [MEM_ADDR_W-1:0] addr;
    logic [MEM_DATA_W-1:0] data;
    logic [MEM_TILES-1:0]  mask;  // One bit per byte tile
  } mem_req_t;

endpackage

//--- hw/mem_subsys_top.sv
module mem_subsys_top #(
  parameter int DATA_WIDTH = mem_pkg::MEM_DATA_W,
  parameter int ADDR_WIDTH = mem_pkg::MEM_ADDR_W
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  mem_pkg::apb_req_t apb_i,
  output mem_pkg::apb_rsp_t apb_o
);

  import mem_pkg::*;

  mem_req_t              mem_req;
  logic [DATA_WIDTH-1:0] mem_rdata;

  apb_mem_bridge #(
    .DATA_WIDTH (DATA_WIDTH),
    .ADDR_WIDTH (ADDR_WIDTH)
  ) u_apb_mem_bridge (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .apb_i       (apb_i),
    .mem_rdata_i (mem_rdata),
    .apb_o       (apb_o),
    .mem_o       (mem_req)
  );

  // Request struct unpacked onto the macro-style pins
  mem_1rw_wrapper #(
    .DATA_WIDTH (DATA_WIDTH),
    .ADDR_WIDTH (ADDR_WIDTH)
  ) u_mem_1rw_wrapper (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .v_i          (mem_req.v),
    .w_i          (mem_req.w),
    .addr_i       (mem_req.addr),
    .data_i       (mem_req.data),
    .write_mask_i (mem_req.mask),
    .data_o       (mem_rdata)
  );

endmodule

//--- hw/sram_256x8.sv
module sram_256x8 (
  input  logic       clk_i,
  input  logic       ce_i,      // Chip enable
  input  logic       we_i,      // Write when high
  input  logic [7:0] w_mask_i,  // Per-bit write enable
  input  logic [7:0] addr_i,
  input  logic [7:0] wd_i,
  output logic [7:0] rd_o
);

  logic [7:0] mem_q [256];

  // Masked write, registered read
  always_ff @(posedge clk_i) begin
    if (ce_i) begin
      if (we_i) begin
        mem_q[addr_i] <= (mem_q[addr_i] & ~w_mask_i) | (wd_i & w_mask_i);
      end else begin
        rd_o <= mem_q[addr_i];  // Holds until the next read
      end
    end
  end

  // Enabled access must point at a real row
  a_addr_known: assert property (
    @(posedge clk_i) ce_i |-> !$isunknown(addr_i)
  ) else $error("sram_256x8: unknown address with ce_i high");

endmodule

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run the testbench and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_mem_subsys -f tb.f --Mdir obj_dir -o sim_tb || exit 1
out=$(./obj_dir/sim_tb)
echo "$out"
echo "$out" | grep -qF '** PASS **' && echo "Simulation passed" ||
  { echo "Simulation failed"; exit 1; }

//--- tb.f
hw/mem_pkg.sv
hw/sram_256x8.sv
hw/mem_1rw_wrapper.sv
hw/apb_mem_bridge.sv
hw/mem_subsys_top.sv
testbench/tb_mem_subsys.sv

//--- testbench/tb_mem_subsys.sv
module tb_mem_subsys;

  timeunit 1ns;
  timeprecision 1ps;

  import mem_pkg::*;

  localparam int RST_CYCLES = 8;
  localparam int HI_W       = MEM_DATA_W - APB_DATA_W;
  localparam int HI_TILES   = MEM_TILES - APB_STRB_W;
  localparam int PAD_W      = 8 * MEM_TILES;

  // One row of the stimulus table
  typedef struct packed {
    logic [2:0]            grp;    // Behavior under test
    logic                  wr;
    logic                  hi;     // Window select
    logic [1:0]            offs;   // Byte offset, nonzero is an error
    logic [MEM_ADDR_W-1:0] idx;
    logic [APB_DATA_W-1:0] wdata;
    logic [APB_STRB_W-1:0] strb;
    logic [APB_DATA_W-1:0] exp_rdata;
    logic                  exp_err;
  } entry_t;

  logic     clk;
  logic     rst_n;
  apb_req_t apb_req;
  apb_rsp_t apb_rsp;

  entry_t table_q[$];
  integer seed = 18538;
  int     cycle_cnt = 0;
  int     cycle_limit = 1000000;
  int     n_checks = 0;
  int     n_errs = 0;

  // Reference state
  logic [MEM_DATA_W-1:0] model_mem [256];
  logic [HI_W-1:0]       stage_data;
  logic [HI_TILES-1:0]   stage_strb;
  logic [HI_W-1:0]       rd_latch;

  mem_subsys_top #(
    .DATA_WIDTH (MEM_DATA_W),
    .ADDR_WIDTH (MEM_ADDR_W)
  ) u_mem_subsys_top (
    .clk_i   (clk),
    .rst_n_i (rst_n),
    .apb_i   (apb_req),
    .apb_o   (apb_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Run limit
  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > cycle_limit) begin
      $display("Timeout: no result after %0d clock cycles", cycle_limit);
      $display("** FAIL **");
      $finish;
    end
  end

  function automatic logic [APB_DATA_W-1:0] rand32();
    logic [31:0] r;
    r = $random(seed);
    return r;
  endfunction

  function automatic logic [MEM_DATA_W-1:0] rand_word();
    logic [63:0] r;
    r = {$random(seed), $random(seed)};
    return r[MEM_DATA_W-1:0];
  endfunction

  function automatic string group_name(input logic [2:0] g);
    case (g)
      3'd1:    return "full word round trip";
      3'd2:    return "byte strobes";
      3'd3:    return "staging cleared after commit";
      3'd4:    return "staged high write";
      3'd5:    return "read latch";
      default: return "unaligned paddr";
    endcase
  endfunction

  // Write row, model follows the staging and commit rules
  task automatic add_write(input logic [2:0] grp, input logic hi,
                           input logic [MEM_ADDR_W-1:0] idx, input logic [1:0] offs,
                           input logic [APB_DATA_W-1:0] data,
                           input logic [APB_STRB_W-1:0] strb);
    entry_t               e;
    logic [PAD_W-1:0]     cur;
    logic [PAD_W-1:0]     upd;
    logic [MEM_TILES-1:0] mask;
    int                   b;
    e = '0;
    e.grp     = grp;
    e.wr      = 1'b1;
    e.hi      = hi;
    e.offs    = offs;
    e.idx     = idx;
    e.wdata   = data;
    e.strb    = strb;
    e.exp_err = (offs != 2'b00);
    if (offs == 2'b00) begin
      if (hi) begin
        stage_data = data[HI_W-1:0];
        stage_strb = strb[HI_TILES-1:0];
      end else begin
        cur  = PAD_W'(model_mem[idx]);
        upd  = PAD_W'({stage_data, data});
        mask = {stage_strb, strb};
        for (b = 0; b < MEM_TILES; b++) begin
          if (mask[b]) cur[8*b +: 8] = upd[8*b +: 8];
        end
        model_mem[idx] = cur[MEM_DATA_W-1:0];
        stage_strb     = '0;
      end
    end
    table_q.push_back(e);
  endtask

  task automatic add_read(input logic [2:0] grp, input logic hi,
                          input logic [MEM_ADDR_W-1:0] idx, input logic [1:0] offs);
    entry_t e;
    e = '0;
    e.grp     = grp;
    e.hi      = hi;
    e.offs    = offs;
    e.idx     = idx;
    e.exp_err = (offs != 2'b00);
    if (offs == 2'b00) begin
      if (hi) begin
        e.exp_rdata = APB_DATA_W'(rd_latch);
      end else begin
        e.exp_rdata = model_mem[idx][APB_DATA_W-1:0];
        rd_latch    = model_mem[idx][MEM_DATA_W-1:APB_DATA_W];
      end
    end
    table_q.push_back(e);
  endtask

  // High window then low window, all strobes
  task automatic add_word(input logic [2:0] grp, input logic [MEM_ADDR_W-1:0] idx,
                          input logic [MEM_DATA_W-1:0] w);
    add_write(grp, 1'b1, idx, 2'b00, APB_DATA_W'(w[MEM_DATA_W-1:APB_DATA_W]), 4'b0011);
    add_write(grp, 1'b0, idx, 2'b00, w[APB_DATA_W-1:0], 4'b1111);
  endtask

  task automatic build_table();
    logic [MEM_ADDR_W-1:0] idx;
    logic [MEM_DATA_W-1:0] w;
    logic [APB_STRB_W-1:0] strbs [6];
    int                    k;
    strbs      = '{4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0110, 4'b1001};
    stage_data = '0;
    stage_strb = '0;
    rd_latch   = '0;
    for (k = 0; k < 16; k++) begin
      if (k == 0) idx = 8'd0;
      else if (k == 15) idx = 8'd255;
      else idx = 8'((k * 37 + 5) % 256);  // Spread over the array
      add_word(3'd1, idx, rand_word());
      add_read(3'd1, 1'b0, idx, 2'b00);
      add_read(3'd1, 1'b1, idx, 2'b00);
    end
    // Known contents for the words the later tests read back
    add_word(3'd1, 8'd42, rand_word());
    add_word(3'd1, 8'd116, rand_word());
    add_word(3'd1, 8'd153, rand_word());
    add_word(3'd1, 8'd190, rand_word());
    add_word(3'd1, 8'd8, rand_word());
    for (k = 0; k < 6; k++) begin
      add_write(3'd2, 1'b0, 8'd42, 2'b00, rand32(), strbs[k]);
      add_read(3'd2, 1'b0, 8'd42, 2'b00);
      add_read(3'd2, 1'b1, 8'd42, 2'b00);
    end
    add_word(3'd3, 8'd79, rand_word());
    add_write(3'd3, 1'b0, 8'd79, 2'b00, rand32(), 4'b1111);  // Low only
    add_read(3'd3, 1'b0, 8'd79, 2'b00);
    add_read(3'd3, 1'b1, 8'd79, 2'b00);
    add_write(3'd3, 1'b0, 8'd116, 2'b00, rand32(), 4'b1111);
    add_read(3'd3, 1'b0, 8'd116, 2'b00);
    add_read(3'd3, 1'b1, 8'd116, 2'b00);
    w = rand_word();
    add_write(3'd4, 1'b1, 8'd153, 2'b00, APB_DATA_W'(w[MEM_DATA_W-1:APB_DATA_W]), 4'b0011);
    add_read(3'd4, 1'b0, 8'd153, 2'b00);
    add_read(3'd4, 1'b1, 8'd153, 2'b00);   // Still the old high bits
    add_write(3'd4, 1'b0, 8'd153, 2'b00, w[APB_DATA_W-1:0], 4'b1111);
    add_read(3'd4, 1'b0, 8'd153, 2'b00);
    add_read(3'd4, 1'b1, 8'd153, 2'b00);
    add_write(3'd4, 1'b1, 8'd153, 2'b00, rand32(), 4'b0001);  // Tile 4 only
    add_write(3'd4, 1'b0, 8'd153, 2'b00, rand32(), 4'b0000);
    add_read(3'd4, 1'b0, 8'd153, 2'b00);
    add_read(3'd4, 1'b1, 8'd153, 2'b00);
    add_read(3'd5, 1'b0, 8'd190, 2'b00);
    add_word(3'd5, 8'd227, rand_word());
    add_read(3'd5, 1'b1, 8'd190, 2'b00);
    add_read(3'd5, 1'b1, 8'd227, 2'b00);   // Window index does not matter
    add_read(3'd5, 1'b0, 8'd227, 2'b00);
    add_read(3'd5, 1'b1, 8'd227, 2'b00);
    add_write(3'd6, 1'b0, 8'd8, 2'b01, rand32(), 4'b1111);
    add_write(3'd6, 1'b1, 8'd8, 2'b10, rand32(), 4'b0011);
    add_read(3'd6, 1'b0, 8'd8, 2'b11);
    add_read(3'd6, 1'b0, 8'd8, 2'b00);
    add_read(3'd6, 1'b1, 8'd8, 2'b00);
    add_write(3'd6, 1'b0, 8'd8, 2'b00, rand32(), 4'b1111);  // Nothing staged before
    add_read(3'd6, 1'b0, 8'd8, 2'b00);
    add_read(3'd6, 1'b1, 8'd8, 2'b00);
  endtask

  // Setup then access, held until pready
  task automatic apb_transfer(input entry_t e, output logic [APB_DATA_W-1:0] rdata,
                              output logic err, output int n_acc);
    @(posedge clk);
    #5;
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = e.wr;
    apb_req.paddr   = {e.idx, e.hi, e.offs};
    apb_req.pwdata  = e.wdata;
    apb_req.pstrb   = e.strb;
    @(posedge clk);
    #5;
    apb_req.penable = 1'b1;
    n_acc = 1;
    @(negedge clk);  // Sample mid-cycle
    while (!apb_rsp.pready) begin
      @(negedge clk);
      n_acc++;
    end
    rdata = apb_rsp.prdata;
    err   = apb_rsp.pslverr;
  endtask

  initial begin
    entry_t                e;
    logic [APB_DATA_W-1:0] rdata;
    logic                  err;
    int                    n_acc;
    int                    exp_acc;
    int                    grp_cnt;
    int                    grp_errs;
    apb_req  = '0;
    rst_n    = 1'b0;
    grp_cnt  = 0;
    grp_errs = 0;
    build_table();
    cycle_limit = 4 * table_q.size() + RST_CYCLES + 50;
    repeat (RST_CYCLES) @(posedge clk);
    #5;
    rst_n = 1'b1;
    for (int i = 0; i < table_q.size(); i++) begin
      e = table_q[i];
      apb_transfer(e, rdata, err, n_acc);
      exp_acc = (!e.wr && !e.hi && !e.exp_err) ? 2 : 1;  // Low read waits once
      grp_cnt++;
      n_checks++;
      assert (err === e.exp_err) else begin
        $display("[FAIL] %0d ns: entry %0d pslverr %b, expected %b", $time, i, err, e.exp_err);
        n_errs++;
        grp_errs++;
      end
      n_checks++;
      assert (n_acc == exp_acc) else begin
        $display("[FAIL] %0d ns: entry %0d took %0d access cycles, expected %0d",
                 $time, i, n_acc, exp_acc);
        n_errs++;
        grp_errs++;
      end
      if (!e.wr && !e.exp_err) begin
        n_checks++;
        assert (rdata === e.exp_rdata) else begin
          $display("[FAIL] %0d ns: entry %0d word %0d %s prdata 0x%08h, expected 0x%08h",
                   $time, i, e.idx, e.hi ? "high" : "low", rdata, e.exp_rdata);
          n_errs++;
          grp_errs++;
        end
      end
      if (i == table_q.size() - 1 || table_q[i+1].grp != e.grp) begin
        $display("Test %0d (%s): %0d transfers, %0d errors",
                 e.grp, group_name(e.grp), grp_cnt, grp_errs);
        grp_cnt  = 0;
        grp_errs = 0;
      end
    end
    @(posedge clk);
    #5;
    apb_req.psel    = 1'b0;
    apb_req.penable = 1'b0;
    $display("Summary: %0d checks, %0d errors", n_checks, n_errs);
    if (n_errs == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule
